//--- bench/cache_asserts.sv
//****************************************
// fill machine protocol assertions, bound into cache_fill_fsm
//****************************************
`timescale 1ns/1ns

module cache_fill_asserts (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic memory_read,
    input logic write_data_array,
    input logic write_tag_array
);

    // the tag and valid bit are written in the last busy cycle, the fill ends at that edge
    tag_write_in_fill: assert property (@(posedge clk) disable iff (reset)
        write_tag_array |=> !busy)
        else $error("busy stayed high after write_tag_array");

    // memory is only read on behalf of a fill
    read_in_fill: assert property (@(posedge clk) disable iff (reset)
        memory_read |-> busy)
        else $error("memory_read strobed while the fill machine was idle");

    // the tag write follows the last word by one cycle and never lands together with it
    tag_after_data: assert property (@(posedge clk) disable iff (reset)
        write_tag_array |-> !write_data_array && $past(write_data_array))
        else $error("write_tag_array not in the cycle right after the last data write");

endmodule

bind cache_fill_fsm cache_fill_asserts fill_checks (
    .clk(clk),
    .reset(reset),
    .busy(busy),
    .memory_read(memory_read),
    .write_data_array(write_data_array),
    .write_tag_array(write_tag_array)
);

//--- bench/cache_patterns.txt
# each line holds op address write_data expected_read in hex
# op R reads and W writes, writes keep expected at 0000
R 0040 0000 0000
W 1230 abcd 0000
W 1233 1357 0000
W 1237 2468 0000
R 1233 0000 1357
R 1230 0000 abcd
R 1237 0000 2468
R 1231 0000 0000
R 1236 0000 0000
R 1232 0000 0000
R 1234 0000 0000
R 1235 0000 0000
W 1235 5a5a 0000
R 1235 0000 5a5a
R 3431 0000 0000
R 1235 0000 5a5a
R 3431 0000 0000
W 0045 7777 0000
R 0045 0000 7777
R ff47 0000 0000
R 0045 0000 7777
R fff8 0000 0000
W fff8 0bad 0000
R fff8 0000 0bad
R 0040 0000 0000

//--- bench/cache_tb.sv
//****************************************
// cache testbench, pattern file accesses checked
// against a shadow memory and a shadow tag table
//****************************************
`timescale 1ns/1ns

module cache_tb;

    localparam int MEM_LATENCY = 4;
    localparam int MEM_WORDS   = 65536;
    localparam int WAIT_LIMIT  = 64; // cycles allowed for any single wait

    logic             clk;
    logic             reset;
    logic             read;
    logic             write;
    cache_pkg::addr_t address;
    cache_pkg::word_t write_data;
    cache_pkg::word_t read_data;
    logic             stall;

    // what memory and the tag store should hold after each completed access
    cache_pkg::word_t shadow_mem   [MEM_WORDS];
    cache_pkg::tag_t  shadow_tag   [cache_pkg::NUM_BLOCKS];
    logic             shadow_valid [cache_pkg::NUM_BLOCKS];

    int access_count; // accesses taken from the pattern file

    clock_gen clocks (
        .clk(clk),
        .reset(reset)
    );

    cache_top #(.MEM_LATENCY(MEM_LATENCY), .MEM_WORDS(MEM_WORDS)) UUT (
        .clk(clk),
        .reset(reset),
        .read(read),
        .write(write),
        .address(address),
        .write_data(write_data),
        .read_data(read_data),
        .stall(stall)
    );

    task automatic check_word(input string name, input cache_pkg::word_t actual,
                              input cache_pkg::word_t expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, actual, expected);
            $display("test failed");
            $fatal(1, "data word mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s got %b expected %b", $time, name, actual, expected);
            $display("test failed");
            $fatal(1, "control flag mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%0t ns %s", $time, what);
        $display("test failed");
        $fatal(1, "run stopped on a failure");
    endtask

    // reset is released on an edge, so it is looked at on the falling edge
    task automatic wait_for_reset_release();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (reset !== 1'b0)
            report_failure("reset was never released");
    endtask

    // a miss holds stall for the whole fill, the read then completes as a hit
    task automatic wait_for_stall_low(input cache_pkg::addr_t addr);
        int cycles;
        cycles = 0;
        while (stall !== 1'b0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (stall !== 1'b0)
            report_failure($sformatf("stall never cleared on the read of address %h", addr));
    endtask

    task automatic do_read(input cache_pkg::addr_t addr, input cache_pkg::word_t file_word);
        cache_pkg::cache_addr_t split;
        logic                   expect_hit;
        split.raw  = addr;
        expect_hit = shadow_valid[split.fields.index]
                   && (shadow_tag[split.fields.index] == split.fields.tag);
        @(posedge clk);
        read    <= 1'b1;
        write   <= 1'b0;
        address <= addr;
        @(negedge clk);
        check_flag("stall", stall, !expect_hit); // a hit answers in its first cycle
        wait_for_stall_low(addr);
        check_word("read_data", read_data, file_word);
        check_word("read_data vs shadow memory", read_data, shadow_mem[addr]);
        // a completed read leaves its block resident
        shadow_valid[split.fields.index] = 1'b1;
        shadow_tag[split.fields.index]   = split.fields.tag;
        access_count++;
    endtask

    task automatic do_write(input cache_pkg::addr_t addr, input cache_pkg::word_t data);
        @(posedge clk);
        read       <= 1'b0;
        write      <= 1'b1;
        address    <= addr;
        write_data <= data;
        @(negedge clk);
        check_flag("stall", stall, 1'b0); // write through finishes in one cycle
        shadow_mem[addr] = data;          // no allocate, the tags stay as they were
        access_count++;
    endtask

    // 0 to 3 quiet cycles between accesses, zero keeps them back to back
    task automatic idle_gap();
        int gap;
        gap = $urandom % 4;
        repeat (gap) begin
            @(posedge clk);
            read  <= 1'b0;
            write <= 1'b0;
        end
    endtask

    initial begin
        int               fd;
        int               count;
        string            line;
        logic [7:0]       op;
        cache_pkg::addr_t addr;
        cache_pkg::word_t wdata;
        cache_pkg::word_t expected;

        read         = 1'b0;
        write        = 1'b0;
        address      = '0;
        write_data   = '0;
        access_count = 0;
        void'($urandom(69));

        // main memory comes up as zeros and every block starts invalid
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow_mem[cache_pkg::addr_t'(i)] = '0;
        end
        for (int b = 0; b < cache_pkg::NUM_BLOCKS; b++) begin
            shadow_valid[cache_pkg::index_t'(b)] = 1'b0;
            shadow_tag[cache_pkg::index_t'(b)]   = '0;
        end

        fd = $fopen("bench/cache_patterns.txt", "r");
        if (fd == 0)
            report_failure("could not open bench/cache_patterns.txt");

        wait_for_reset_release();
        check_flag("stall", stall, 1'b0); // fill machine idle out of reset

        while (!$feof(fd)) begin
            line  = "";
            count = $fgets(line, fd);
            if (count != 0 && line.len() > 0 && line[0] != "#") begin
                count = $sscanf(line, "%s %h %h %h", op, addr, wdata, expected);
                if (count == 4) begin
                    if (op == "R")
                        do_read(addr, expected);
                    else if (op == "W")
                        do_write(addr, wdata);
                    else
                        report_failure($sformatf("unknown operation in pattern line %s", line));
                    idle_gap();
                end else if (count > 0) begin
                    report_failure($sformatf("malformed pattern line %s", line));
                end
            end
        end
        $fclose(fd);

        @(posedge clk);
        read  <= 1'b0;
        write <= 1'b0;
        @(negedge clk);

        if (access_count == 0) begin
            $display("no accesses were found in the pattern file");
            $display("test failed");
            $fatal(1, "empty pattern file");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- bench/clock_gen.sv
//****************************************
// testbench clock and power-on reset
//****************************************
`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD       = 100, // clock period in ns
    parameter int RESET_CYCLES = 16   // rising edges with reset held high
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset drops on a rising edge, like any other synchronous input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- hw/cache_data_array.sv
//****************************************
// cache data store, combinational read and clocked write
//****************************************
`timescale 1ns/1ns

module cache_data_array (
    input  logic               clk,
    input  logic               reset,
    input  logic               write_enable,
    input  cache_pkg::index_t  write_index,
    input  cache_pkg::offset_t write_offset,
    input  cache_pkg::word_t   write_word,
    input  cache_pkg::index_t  read_index,
    input  cache_pkg::offset_t read_offset,
    output cache_pkg::word_t   read_word
);

    localparam int DEPTH = cache_pkg::NUM_BLOCKS * cache_pkg::WORDS_PER_BLOCK;

    // one flat array, block index on the top bits and word offset below
    cache_pkg::word_t words [DEPTH];

    logic [7:0] write_slot;
    logic [7:0] read_slot;

    assign write_slot = {write_index, write_offset};
    assign read_slot  = {read_index, read_offset};

    // contents are meaningless until the tag array marks the block valid
    always_ff @(posedge clk) begin
        if (write_enable && !reset)
            words[write_slot] <= write_word; // no writes land while reset is held
    end

    // read is asynchronous so a hit returns its word in the same cycle
    assign read_word = words[read_slot];

endmodule

//--- hw/cache_fill_fsm.sv
//****************************************
// miss fill state machine with request and receive counters
//****************************************
`timescale 1ns/1ns

module cache_fill_fsm (
    input  logic                    clk,
    input  logic                    reset,
    input  cache_pkg::cache_addr_t  miss_address,      // held by the processor during the fill
    input  logic                    service,           // a read missed and needs a block
    input  logic                    memory_data_valid, // a requested word is on the memory bus
    output logic                    busy,              // high while a block is being filled
    output logic                    memory_read,       // one read strobe per requested word
    output cache_pkg::addr_t        memory_address,
    output cache_pkg::offset_t      offset,            // word of the block to write now
    output logic                    write_data_array,
    output logic                    write_tag_array
);

    // offset of the eighth word, the point where both counters wrap
    localparam cache_pkg::offset_t LAST_WORD = cache_pkg::offset_t'(cache_pkg::WORDS_PER_BLOCK - 1);

    logic                   requesting;     // still issuing reads to memory
    cache_pkg::offset_t     request_count;  // next word to request
    cache_pkg::offset_t     receive_count;  // next word expected back
    cache_pkg::cache_addr_t request_addr;
    logic                   fill_done;

    // requests are pipelined, so the request side runs ahead of the receive side
    // and several words can be in flight at once
    always_comb begin
        request_addr              = miss_address;
        request_addr.fields.offset = request_count; // block base plus request count
    end

    assign memory_address = request_addr.raw;
    assign memory_read    = requesting;

    // every request has gone out and the receive count has wrapped back to zero,
    // the valid check keeps the first arrival at the longest latency from looking done
    assign fill_done = busy & ~requesting & ~memory_data_valid
                     & (request_count == '0) & (receive_count == '0);

    assign write_data_array = busy & memory_data_valid; // store each word as it arrives
    assign write_tag_array  = fill_done;                // one pulse after the last word
    assign offset           = receive_count;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy          <= 1'b0;
            requesting    <= 1'b0;
            request_count <= '0;
            receive_count <= '0;
        end else begin
            if (!busy && service) begin
                // accept the miss, the first request goes out in the first busy cycle
                busy          <= 1'b1;
                requesting    <= 1'b1;
                request_count <= '0;
                receive_count <= '0;
            end else if (fill_done) begin
                busy <= 1'b0; // the held read hits in the next cycle
            end

            if (requesting) begin
                request_count <= request_count + 3'd1;
                if (request_count == LAST_WORD)
                    requesting <= 1'b0; // eight requests issued
            end

            // arrivals are counted on their own, independent of the request side
            if (write_data_array)
                receive_count <= receive_count + 3'd1;
        end
    end

endmodule

//--- hw/cache_pkg.sv
//****************************************
// shared word, address and field types for the cache,
// the address union and the cache geometry
//****************************************
package cache_pkg;

    // cache geometry, 32 blocks of 8 words each
    localparam int WORDS_PER_BLOCK = 8;
    localparam int NUM_BLOCKS      = 32;

    typedef logic [15:0] word_t;  // one data word, memory is word addressed
    typedef logic [15:0] addr_t;  // one word address

    // field widths follow from the geometry above
    typedef logic [7:0] tag_t;    // upper address bits kept per block
    typedef logic [4:0] index_t;  // selects one of the NUM_BLOCKS blocks
    typedef logic [2:0] offset_t; // selects one word inside a block

    // tag sits on the top bits so that raw and fields line up
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } cache_fields_t;

    // the same 16 bits seen either as a plain word address or split for lookup
    typedef union packed {
        addr_t         raw;
        cache_fields_t fields;
    } cache_addr_t;

endpackage

//--- hw/cache_tag_array.sv
//****************************************
// tag and valid store with the hit compare
//****************************************
`timescale 1ns/1ns

module cache_tag_array (
    input  logic              clk,
    input  logic              reset,
    input  cache_pkg::index_t index,     // block being looked up or filled
    input  cache_pkg::tag_t   tag,       // tag to compare against or to store
    input  logic              write_tag, // end of a fill, store tag and set valid
    output logic              hit
);

    cache_pkg::tag_t                      tags [cache_pkg::NUM_BLOCKS];
    logic [cache_pkg::NUM_BLOCKS-1:0]     valid;

    // every block starts empty, so the first read of any address misses
    always_ff @(posedge clk) begin
        if (reset)
            valid <= '0;
        else if (write_tag)
            valid[index] <= 1'b1;
    end

    // stored tags are only looked at through the valid bit
    always_ff @(posedge clk) begin
        if (write_tag)
            tags[index] <= tag;
    end

    // direct mapped, so only the one addressed entry can match
    assign hit = valid[index] && (tags[index] == tag);

endmodule

//--- hw/cache_top.sv
//****************************************
// cache top level, arrays, fill machine and memory
//****************************************
`timescale 1ns/1ns

module cache_top #(
    parameter int MEM_LATENCY = 4,
    parameter int MEM_WORDS   = 65536
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             read,
    input  logic             write,
    input  cache_pkg::addr_t address,    // held by the processor until stall drops
    input  cache_pkg::word_t write_data,
    output cache_pkg::word_t read_data,
    output logic             stall
);

    cache_pkg::cache_addr_t access;      // processor address split into fields
    cache_pkg::addr_t       memory_address;
    cache_pkg::word_t       memory_data;
    cache_pkg::offset_t     fill_offset;
    cache_pkg::index_t      array_index;
    cache_pkg::offset_t     array_offset;
    cache_pkg::word_t       array_word;
    logic hit, busy, miss_service, write_hit, array_write;
    logic memory_read, memory_data_valid, write_data_array, write_tag_array;

    assign access.raw = address;

    assign miss_service = read & ~hit;        // a read that must wait for a fill
    assign stall        = busy | miss_service; // held low on a hit, no extra cycle
    assign write_hit    = write & hit & ~busy; // write through, no allocate on a miss

    // fill words and processor writes never meet since writes wait out a busy fill
    assign array_write  = busy ? write_data_array : write_hit;
    assign array_offset = busy ? fill_offset : access.fields.offset;
    assign array_word   = busy ? memory_data : write_data;

    // the processor holds its address through a fill, so the access index
    // also names the block being filled
    assign array_index = access.fields.index;

    cache_fill_fsm fill (
        .clk(clk), .reset(reset), .miss_address(access), .service(miss_service),
        .memory_data_valid(memory_data_valid), .busy(busy), .memory_read(memory_read),
        .memory_address(memory_address), .offset(fill_offset),
        .write_data_array(write_data_array), .write_tag_array(write_tag_array)
    );

    cache_data_array data_array (
        .clk(clk), .reset(reset), .write_enable(array_write), .write_index(array_index),
        .write_offset(array_offset), .write_word(array_word),
        .read_index(access.fields.index), .read_offset(access.fields.offset),
        .read_word(read_data)
    );

    // lookup and the end-of-fill tag write both use the held access address
    cache_tag_array tag_array (
        .clk(clk), .reset(reset), .index(access.fields.index), .tag(access.fields.tag),
        .write_tag(write_tag_array), .hit(hit)
    );

    // every processor write goes straight to memory
    main_memory #(.MEM_LATENCY(MEM_LATENCY), .MEM_WORDS(MEM_WORDS)) memory (
        .clk(clk), .reset(reset), .read(memory_read), .read_address(memory_address),
        .write(write), .write_address(address), .write_word(write_data),
        .data(memory_data), .data_valid(memory_data_valid)
    );

endmodule

//--- hw/main_memory.sv
//****************************************
// main memory with pipelined reads of set latency
// and single cycle writes
//****************************************
`timescale 1ns/1ns

module main_memory #(
    parameter int MEM_LATENCY = 4,     // cycles from read strobe to data_valid
    parameter int MEM_WORDS   = 65536  // depth in words
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             read,
    input  cache_pkg::addr_t read_address,
    input  logic             write,
    input  cache_pkg::addr_t write_address,
    input  cache_pkg::word_t write_word,
    output cache_pkg::word_t data,
    output logic             data_valid
);

    localparam int ADDR_BITS = $clog2(MEM_WORDS);

    cache_pkg::word_t mem [MEM_WORDS];

    // stage 0 is loaded by the strobe, the last stage drives the outputs
    logic [MEM_LATENCY-1:0] valid_pipe;
    cache_pkg::word_t       data_pipe [MEM_LATENCY];

    // memory comes up as all zeros
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // writes land at the edge; a read in the same cycle still sees the old word
    always_ff @(posedge clk) begin
        if (write)
            mem[write_address[ADDR_BITS-1:0]] <= write_word;
    end

    // valid bits must be clean out of reset, so only they are cleared
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= read; // a new request can enter every cycle
            for (int s = 1; s < MEM_LATENCY; s++) begin
                valid_pipe[s] <= valid_pipe[s-1];
            end
        end
    end

    // the word moves along next to its valid bit
    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[read_address[ADDR_BITS-1:0]];
        for (int s = 1; s < MEM_LATENCY; s++) begin
            data_pipe[s] <= data_pipe[s-1];
        end
    end

    assign data       = data_pipe[MEM_LATENCY-1];
    assign data_valid = valid_pipe[MEM_LATENCY-1]; // exactly MEM_LATENCY cycles after read

endmodule

//--- run_sim.sh
#!/bin/sh
# build the cache testbench with Verilator and run it
# exits non-zero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f sim.f -o cache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cache_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

exit 0

//--- sim.f
hw/cache_pkg.sv
hw/cache_data_array.sv
hw/cache_tag_array.sv
hw/cache_fill_fsm.sv
hw/main_memory.sv
hw/cache_top.sv
bench/clock_gen.sv
bench/cache_asserts.sv
bench/cache_tb.sv
